// File: all.f
rtl/adc_acq_pkg.sv
rtl/adc_acq_sequencer.sv
rtl/adc_counters.sv
rtl/adc_dummy_source.sv
rtl/adc_word_builder.sv
rtl/adc_acq_top.sv
bench/adc_acq_assert.sv
bench/adc_acq_checker.sv
bench/adc_acq_tb.sv

// File: bench/adc_acq_assert.sv
`timescale 1ns/10ps

module adc_acq_assert (
    input logic                    clk,
    input logic                    adc_acq_full_reset,
    input logic                    out_valid,
    input logic                    out_ready,
    input adc_acq_pkg::acq_word_t  out_data,
    input adc_acq_pkg::word_addr_t out_addr,
    input logic                    acq_done,
    input logic                    acq_enabled,
    input logic                    sm_idle
);

    // stalled word stays valid and unchanged
    hold_on_stall: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_addr))
        else $error("output word changed while out_ready was low");

    // completion is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        acq_done |=> !acq_done)
        else $error("acq_done held longer than one cycle");

    // nothing left at the output once the sequencer is back in idle
    idle_no_word: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        sm_idle |-> !out_valid)
        else $error("output word in flight while idle");

    // words only go out during a fill
    valid_while_enabled: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        out_valid |-> acq_enabled)
        else $error("output word presented without acq_enabled");

endmodule

bind adc_acq_top adc_acq_assert u_assert (.*);

// File: bench/adc_acq_checker.sv
`timescale 1ns/10ps

module adc_acq_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    acq_enable0,
    input  logic                    acq_enable1,
    input  adc_acq_pkg::burst_len_t burst_len_a,
    input  adc_acq_pkg::burst_len_t burst_len_b,
    input  adc_acq_pkg::burst_len_t burst_len_c,
    input  logic                    dummy_dat_reset_mode,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  adc_acq_pkg::acq_word_t  out_data,
    input  adc_acq_pkg::word_addr_t out_addr,
    input  logic                    acq_enabled,
    input  logic                    acq_done,
    input  logic                    test_active,
    input  logic [127:0]            test_name,
    input  int                      exp_count,
    input  adc_acq_pkg::checksum_t  exp_csum,
    output int                      fail_count,
    output int                      test_count
);
    import adc_acq_pkg::*;

    // reference model state, kept across tests
    word_addr_t exp_addr;
    fill_num_t  exp_fill;
    sample_t    ramp;
    checksum_t  csum;
    burst_len_t len;
    acq_word_t  exp;
    int         widx;
    int         errors;
    int         done_pulses;
    logic       flagged;
    logic       was_active;

    // eight ramp samples, lane 0 lowest, upper nibble of each lane zero
    function automatic acq_word_t ramp_word(input sample_t start);
        acq_word_t w;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            w[16*k +: 12] = start + 12'(k);
        end
        return w;
    endfunction

    function automatic checksum_t slice_sum(input acq_word_t w);
        return w[31:0] + w[63:32] + w[95:64] + w[127:96];
    endfunction

    task compare_word(input string what, input acq_word_t e, input acq_word_t a);
        if (e !== a) begin
            $display("[FAIL] %0s %0s expected %h actual %h", test_name, what, e, a);
            errors++;
        end
    endtask

    task note_problem(input string msg);
        if (!flagged) begin
            $display("test %0s: %0s", test_name, msg);
            errors++;
            flagged = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_addr   = '0;
            exp_fill   = '0;
            ramp       = '0;
            csum       = '0;
            widx       = 0;
            errors     = 0;
            fail_count = 0;
            test_count = 0;
            was_active = 1'b0;
        end else begin
            if (test_active && !was_active) begin
                widx        = 0;
                errors      = 0;
                done_pulses = 0;
                flagged     = 1'b0;
            end
            case ({acq_enable1, acq_enable0})
                2'd1:    len = burst_len_a;
                2'd2:    len = burst_len_b;
                2'd3:    len = burst_len_c;
                default: len = '0;
            endcase
            if (test_active) begin
                if (acq_done) begin
                    done_pulses++;
                end
                if (len == 0 && acq_enabled) begin
                    note_problem("acq_enabled went high with both enables low");
                end
                if (widx > 0 && done_pulses == 0 && !acq_enabled) begin
                    note_problem("acq_enabled dropped before ddr3 write completion");
                end
            end else if (out_valid && out_ready) begin
                $display("word accepted while no test was running");
                fail_count++;
            end
            if (test_active && out_valid && out_ready) begin
                if (out_addr !== exp_addr) begin
                    $display("[FAIL] %0s address expected %h actual %h",
                             test_name, exp_addr, out_addr);
                    errors++;
                end
                if (widx == 0) begin
                    // one waveform per fill, so ramp restart lines up with the fill
                    if (dummy_dat_reset_mode) begin
                        ramp = '0;
                    end
                    csum = '0;
                    exp  = {FILL_HDR_TAG, exp_fill, acq_enable1, acq_enable0, len, 68'd0};
                    compare_word("fill header", exp, out_data);
                end else if (widx == 1) begin
                    exp = {WFM_HDR_TAG, exp_fill, exp_addr, 56'd0};
                    compare_word("waveform header", exp, out_data);
                end else if (widx <= int'(len) + 1) begin
                    exp  = ramp_word(ramp);
                    compare_word("data word", exp, out_data);
                    csum = csum + slice_sum(exp);
                    ramp = ramp + 12'd8;
                end else if (widx == int'(len) + 2) begin
                    exp = {CSUM_TAG, 80'd0, csum};
                    compare_word("checksum word", exp, out_data);
                    if (csum !== exp_csum) begin
                        $display("[FAIL] %0s data file checksum expected %h actual %h",
                                 test_name, exp_csum, csum);
                        errors++;
                    end
                    exp_fill++;
                end else begin
                    note_problem("extra word accepted after the checksum word");
                end
                exp_addr++;
                widx++;
            end
            if (!test_active && was_active) begin
                if (widx != exp_count) begin
                    $display("[FAIL] %0s word count expected %0d actual %0d",
                             test_name, exp_count, widx);
                    errors++;
                end
                if (done_pulses != (exp_count > 0 ? 1 : 0)) begin
                    $display("[FAIL] %0s acq_done pulses expected %0d actual %0d",
                             test_name, exp_count > 0 ? 1 : 0, done_pulses);
                    errors++;
                end
                test_count++;
                if (errors != 0) begin
                    fail_count++;
                end
                $display("test %0s: %0d words, %0d errors", test_name, widx, errors);
            end
            was_active = test_active;
        end
    end

endmodule

// File: bench/adc_acq_tb.sv
`timescale 1ns/10ps

module adc_acq_tb;
    import adc_acq_pkg::*;

    localparam int MAX_TESTS = 16;

    logic       clk;
    logic       adc_acq_full_reset;
    logic       acq_enable0;
    logic       acq_enable1;
    logic       acq_trig = 1'b0;
    logic       dummy_dat_reset_mode;
    burst_len_t burst_len_a;
    burst_len_t burst_len_b;
    burst_len_t burst_len_c;
    logic       out_ready = 1'b1;
    logic       ddr3_wr_done;
    logic       out_valid;
    acq_word_t  out_data;
    word_addr_t out_addr;
    logic       acq_enabled;
    logic       acq_done;
    logic       sm_idle;

    // per test fields en1 en0 len_a len_b len_c mode rand done_dly trig_hold count
    logic [127:0] t_name [MAX_TESTS];
    int           t_f    [MAX_TESTS][10];
    checksum_t    t_csum [MAX_TESTS];
    int           num_tests = 0;
    int           cycle_count = 0;
    int           cycle_limit = 0;
    int           trig_until = 0;
    logic         rand_ready = 1'b0;
    logic [15:0]  lfsr = 16'd39767;
    logic         test_active;
    logic [127:0] cur_name;
    int           cur_count;
    checksum_t    cur_csum;
    int           fail_count;
    int           test_count;

    adc_acq_top DUT (.*);

    adc_acq_checker u_checker (
        .clk, .rst(adc_acq_full_reset), .acq_enable0, .acq_enable1,
        .burst_len_a, .burst_len_b, .burst_len_c, .dummy_dat_reset_mode,
        .out_valid, .out_ready, .out_data, .out_addr, .acq_enabled, .acq_done,
        .test_active, .test_name(cur_name), .exp_count(cur_count), .exp_csum(cur_csum),
        .fail_count, .test_count
    );

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: no completion within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ready and trigger move on the falling edge with one lfsr step per ready bit
    always @(negedge clk) begin
        if (rand_ready) begin
            lfsr      = lfsr_step(lfsr);
            out_ready <= lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
        acq_trig <= cycle_count < trig_until;
    end

    task automatic read_tests();
        int    fd;
        int    n;
        int    len_sum;
        string line;
        fd      = $fopen("bench/adc_acq_testdata.txt", "r");
        len_sum = 0;
        if (fd == 0) begin
            $display("could not open bench/adc_acq_testdata.txt");
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 3 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %h",
                            t_name[num_tests], t_f[num_tests][0], t_f[num_tests][1],
                            t_f[num_tests][2], t_f[num_tests][3], t_f[num_tests][4],
                            t_f[num_tests][5], t_f[num_tests][6], t_f[num_tests][7],
                            t_f[num_tests][8], t_f[num_tests][9], t_csum[num_tests]);
                if (n == 12) begin
                    // stalls can stretch each burst; allow 40 cycles per burst
                    len_sum += t_f[num_tests][2] + t_f[num_tests][3] + t_f[num_tests][4];
                    cycle_limit += t_f[num_tests][7] + t_f[num_tests][8] + 200;
                    num_tests++;
                end
            end
            $fclose(fd);
            cycle_limit += 2000 + 40 * len_sum;
        end
    endtask

    task automatic run_test(input int i);
        int trig_end;
        @(negedge clk);
        acq_enable1          = t_f[i][0][0];
        acq_enable0          = t_f[i][1][0];
        burst_len_a          = burst_len_t'(t_f[i][2]);
        burst_len_b          = burst_len_t'(t_f[i][3]);
        burst_len_c          = burst_len_t'(t_f[i][4]);
        dummy_dat_reset_mode = t_f[i][5][0];
        rand_ready          <= t_f[i][6] != 0;
        cur_name             = t_name[i];
        cur_count            = t_f[i][9];
        cur_csum             = t_csum[i];
        test_active          = 1'b1;
        // enables settle through the synchronizers before the trigger
        repeat (10) @(negedge clk);
        trig_end   = cycle_count + t_f[i][8];
        trig_until <= trig_end;
        if (cur_count != 0) begin
            // checksum tag cannot occur in a data word since lanes are 12 bits
            do @(posedge clk);
            while (!(out_valid && out_ready && out_data[127:112] == CSUM_TAG));
            @(negedge clk);
            repeat (t_f[i][7]) @(negedge clk);
            ddr3_wr_done = 1'b1;
            do @(negedge clk);
            while (!acq_done);
            ddr3_wr_done = 1'b0;
            while (!sm_idle) @(negedge clk);
        end else begin
            while (cycle_count < trig_end + 20) @(negedge clk);
        end
        rand_ready <= 1'b0;
        repeat (4) @(negedge clk);
        test_active = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        adc_acq_full_reset   = 1'b1;
        acq_enable0          = 1'b0;
        acq_enable1          = 1'b0;
        dummy_dat_reset_mode = 1'b0;
        burst_len_a          = '0;
        burst_len_b          = '0;
        burst_len_c          = '0;
        ddr3_wr_done         = 1'b0;
        test_active          = 1'b0;
        cur_name             = '0;
        cur_count            = 0;
        cur_csum             = '0;
        read_tests();
        repeat (2) @(negedge clk);
        adc_acq_full_reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        repeat (10) @(negedge clk);
        $display("tests run %0d of %0d, failed %0d", test_count, num_tests, fail_count);
        if (fail_count == 0 && test_count == num_tests && num_tests > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: bench/adc_acq_testdata.txt
# name en1 en0 len_a len_b len_c reset_mode rand_ready done_dly trig_hold words checksum
# decimal fields except the checksum (hex); words is bursts + 3, or 0 when disabled
fill_a          0 1 4 6 3 1 0 3 12 7 010000F0
fill_b_cont     1 0 4 6 3 0 0 5 12 9 05400528
fill_c_cont     1 1 4 6 3 0 0 1 12 6 04500444
fill_c_reset    1 1 4 6 3 1 0 7 12 6 00900084
bp_a            0 1 5 6 3 0 1 4 12 8 0370035C
long_trig       1 0 5 2 3 1 0 6 300 5 00400038
disabled        0 0 4 6 3 0 0 0 20 0 00000000
bp_c            1 1 5 2 7 0 1 9 12 10 04D004B4

// File: rtl/adc_acq_pkg.sv
package adc_acq_pkg;

    // one 128-bit word toward the ddr3 write path
    typedef logic [127:0] acq_word_t;
    // raw adc sample
    typedef logic [11:0]  sample_t;
    // bursts per waveform, 1 to 1023
    typedef logic [9:0]   burst_len_t;
    typedef logic [23:0]  word_addr_t;
    typedef logic [31:0]  fill_num_t;
    typedef logic [31:0]  checksum_t;

    // fill type is {enable1, enable0}; zero means not armed
    typedef enum logic [1:0] {
        FILL_OFF = 2'd0,
        FILL_A   = 2'd1,
        FILL_B   = 2'd2,
        FILL_C   = 2'd3
    } fill_type_t;

    // acquisition sequencer states
    typedef enum logic [4:0] {
        IDLE, WATCH_FOR_TRIG,
        FILL_INIT1, FILL_INIT2,
        WAVEFORM_INIT1, WAVEFORM_INIT2, WAVEFORM_INIT3,
        RUN1, RUN2, RUN3, RUN4,
        WAVEFORM_TST1, WAVEFORM_TST2,
        CHECKSUM1, CHECKSUM2,
        DDR3_WAIT, DONE
    } acq_state_t;

    // tags in bits 127:112 of the non-data words
    localparam logic [15:0] FILL_HDR_TAG = 16'hF111;
    localparam logic [15:0] WFM_HDR_TAG  = 16'hA5E0;
    localparam logic [15:0] CSUM_TAG     = 16'hC5C5;

    // eight 16-bit lanes per data word
    localparam int SAMPLES_PER_BURST = 8;

    // synchronizer depths for the async inputs
    localparam int TRIG_SYNC_STAGES = 4;
    localparam int DONE_SYNC_STAGES = 2;

endpackage

// File: rtl/adc_acq_sequencer.sv
`timescale 1ns/10ps

module adc_acq_sequencer (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   ddr3_wr_done,
    input  logic                   dummy_dat_reset_mode,
    input  logic                   burst_zero,
    input  logic                   word_accepted,
    output adc_acq_pkg::fill_type_t fill_type,
    output logic                   sel_fill_hdr,
    output logic                   sel_wfm_hdr,
    output logic                   sel_data,
    output logic                   sel_csum,
    output logic                   word_push,
    output logic                   csum_update,
    output logic                   burst_load,
    output logic                   burst_dec,
    output logic                   dummy_reset,
    output logic                   sample_advance,
    output logic                   fill_advance,
    output logic                   acq_enabled,
    output logic                   acq_done,
    output logic                   sm_idle
);
    import adc_acq_pkg::*;

    // shift-register synchronizers, newest bit at index 0
    logic [TRIG_SYNC_STAGES-1:0] en0_sync;
    logic [TRIG_SYNC_STAGES-1:0] en1_sync;
    logic [TRIG_SYNC_STAGES-1:0] trig_sync;
    logic [DONE_SYNC_STAGES-1:0] done_sync;

    logic       mode_enabled;
    logic       trig_s;
    logic       done_s;
    acq_state_t state;
    acq_state_t state_next;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sync  <= '0;
            en1_sync  <= '0;
            trig_sync <= '0;
            done_sync <= '0;
        end else begin
            en0_sync  <= {en0_sync[TRIG_SYNC_STAGES-2:0], acq_enable0};
            en1_sync  <= {en1_sync[TRIG_SYNC_STAGES-2:0], acq_enable1};
            trig_sync <= {trig_sync[TRIG_SYNC_STAGES-2:0], acq_trig};
            done_sync <= {done_sync[DONE_SYNC_STAGES-2:0], ddr3_wr_done};
        end
    end

    assign trig_s = trig_sync[TRIG_SYNC_STAGES-1];
    assign done_s = done_sync[DONE_SYNC_STAGES-1];

    // armed whenever either enable is set; the pair also picks the fill type
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            mode_enabled <= 1'b0;
            fill_type    <= FILL_OFF;
        end else begin
            mode_enabled <= en0_sync[TRIG_SYNC_STAGES-1] | en1_sync[TRIG_SYNC_STAGES-1];
            fill_type    <= fill_type_t'({en1_sync[TRIG_SYNC_STAGES-1],
                                          en0_sync[TRIG_SYNC_STAGES-1]});
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // FILL_INIT2, WAVEFORM_INIT3, RUN4 and CHECKSUM2 present a word
    // and only move on once the builder reports it taken
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (mode_enabled) begin
                    state_next = WATCH_FOR_TRIG;
                end
            end
            WATCH_FOR_TRIG: begin
                state_next = (mode_enabled && trig_s) ? FILL_INIT1 : IDLE;
            end
            FILL_INIT1:     state_next = FILL_INIT2;
            FILL_INIT2: begin
                if (word_accepted) begin
                    state_next = WAVEFORM_INIT1;
                end
            end
            WAVEFORM_INIT1: state_next = WAVEFORM_INIT2;
            WAVEFORM_INIT2: state_next = WAVEFORM_INIT3;
            WAVEFORM_INIT3: begin
                if (word_accepted) begin
                    state_next = RUN1;
                end
            end
            RUN1:           state_next = RUN2;
            RUN2:           state_next = RUN3;
            RUN3:           state_next = RUN4;
            RUN4: begin
                // last burst already counted off in RUN1
                if (word_accepted) begin
                    state_next = burst_zero ? WAVEFORM_TST1 : RUN1;
                end
            end
            // single waveform per fill, so the test always ends it
            WAVEFORM_TST1:  state_next = WAVEFORM_TST2;
            WAVEFORM_TST2:  state_next = CHECKSUM1;
            CHECKSUM1:      state_next = CHECKSUM2;
            CHECKSUM2: begin
                if (word_accepted) begin
                    state_next = DDR3_WAIT;
                end
            end
            DDR3_WAIT: begin
                if (done_s) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                // hold until the trigger drops, no retrigger on a long pulse
                if (!(mode_enabled && trig_s)) begin
                    state_next = IDLE;
                end
            end
            default:        state_next = IDLE;
        endcase
    end

    // strobes line up with the state being entered
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            sel_fill_hdr   <= 1'b0;
            sel_wfm_hdr    <= 1'b0;
            sel_data       <= 1'b0;
            sel_csum       <= 1'b0;
            word_push      <= 1'b0;
            csum_update    <= 1'b0;
            burst_load     <= 1'b0;
            burst_dec      <= 1'b0;
            dummy_reset    <= 1'b0;
            sample_advance <= 1'b0;
            fill_advance   <= 1'b0;
            acq_enabled    <= 1'b0;
            acq_done       <= 1'b0;
            sm_idle        <= 1'b1;
        end else begin
            sel_fill_hdr   <= state_next == FILL_INIT1;
            sel_wfm_hdr    <= state_next == WAVEFORM_INIT2;
            sel_data       <= state_next == RUN3;
            sel_csum       <= state_next == CHECKSUM1;
            // load the output register one state ahead of presenting
            word_push      <= state_next inside {FILL_INIT1, WAVEFORM_INIT2, RUN3, CHECKSUM1};
            csum_update    <= state_next == RUN3;
            burst_load     <= state_next == WAVEFORM_INIT2;
            burst_dec      <= state_next == RUN1;
            // 0 -> free-running ramp, 1 -> restart every waveform
            dummy_reset    <= (state_next == WAVEFORM_INIT1) && dummy_dat_reset_mode;
            // fetch the burst early so it is settled by RUN3
            sample_advance <= state_next == RUN1;
            // stays up across a stall in CHECKSUM2
            fill_advance   <= state_next == CHECKSUM2;
            // low while waiting for a trigger, so ddr3 may be read
            acq_enabled    <= !(state_next inside {IDLE, WATCH_FOR_TRIG});
            acq_done       <= (state_next == DONE) && (state != DONE);
            sm_idle        <= state_next == IDLE;
        end
    end

endmodule

// File: rtl/adc_acq_top.sv
`timescale 1ns/10ps

module adc_acq_top (
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  logic                    acq_enable0,
    input  logic                    acq_enable1,
    input  logic                    acq_trig,
    input  logic                    dummy_dat_reset_mode,
    input  adc_acq_pkg::burst_len_t burst_len_a,
    input  adc_acq_pkg::burst_len_t burst_len_b,
    input  adc_acq_pkg::burst_len_t burst_len_c,
    input  logic                    out_ready,
    input  logic                    ddr3_wr_done,
    output logic                    out_valid,
    output adc_acq_pkg::acq_word_t  out_data,
    output adc_acq_pkg::word_addr_t out_addr,
    output logic                    acq_enabled,
    output logic                    acq_done,
    output logic                    sm_idle
);
    import adc_acq_pkg::*;

    // sequencer strobes
    fill_type_t fill_type;
    logic       sel_fill_hdr;
    logic       sel_wfm_hdr;
    logic       sel_data;
    logic       sel_csum;
    logic       word_push;
    logic       csum_update;
    logic       burst_load;
    logic       burst_dec;
    logic       dummy_reset;
    logic       sample_advance;
    logic       fill_advance;
    // counter and builder feedback
    logic       burst_zero;
    logic       word_accepted;
    burst_len_t sel_burst_len;
    word_addr_t word_addr;
    fill_num_t  fill_num;
    acq_word_t  burst_data;

    adc_acq_sequencer u_sequencer (
        .clk, .adc_acq_full_reset,
        .acq_enable0, .acq_enable1, .acq_trig, .ddr3_wr_done,
        .dummy_dat_reset_mode, .burst_zero, .word_accepted,
        .fill_type, .sel_fill_hdr, .sel_wfm_hdr, .sel_data, .sel_csum,
        .word_push, .csum_update, .burst_load, .burst_dec,
        .dummy_reset, .sample_advance, .fill_advance,
        .acq_enabled, .acq_done, .sm_idle
    );

    adc_counters u_counters (
        .clk, .adc_acq_full_reset,
        .fill_type, .burst_len_a, .burst_len_b, .burst_len_c,
        .burst_load, .burst_dec, .word_accepted, .fill_advance,
        .burst_zero, .sel_burst_len, .word_addr, .fill_num
    );

    adc_dummy_source u_dummy_source (
        .clk, .adc_acq_full_reset,
        .dummy_reset, .sample_advance, .burst_data
    );

    adc_word_builder u_word_builder (
        .clk, .adc_acq_full_reset,
        .sel_fill_hdr, .sel_wfm_hdr, .sel_data, .sel_csum,
        .word_push, .csum_update, .out_ready, .burst_data,
        .fill_type, .sel_burst_len, .word_addr, .fill_num,
        .out_valid, .out_data, .out_addr, .word_accepted
    );

endmodule

// File: rtl/adc_counters.sv
`timescale 1ns/10ps

module adc_counters (
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  adc_acq_pkg::fill_type_t fill_type,
    input  adc_acq_pkg::burst_len_t burst_len_a,
    input  adc_acq_pkg::burst_len_t burst_len_b,
    input  adc_acq_pkg::burst_len_t burst_len_c,
    input  logic                    burst_load,
    input  logic                    burst_dec,
    input  logic                    word_accepted,
    input  logic                    fill_advance,
    output logic                    burst_zero,
    output adc_acq_pkg::burst_len_t sel_burst_len,
    output adc_acq_pkg::word_addr_t word_addr,
    output adc_acq_pkg::fill_num_t  fill_num
);
    import adc_acq_pkg::*;

    burst_len_t burst_cnt;

    // length per fill type; FILL_OFF never starts a fill
    always_comb begin
        case (fill_type)
            FILL_A:  sel_burst_len = burst_len_a;
            FILL_B:  sel_burst_len = burst_len_b;
            FILL_C:  sel_burst_len = burst_len_c;
            default: sel_burst_len = '0;
        endcase
    end

    // counts down once per issued burst
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cnt <= '0;
        end else if (burst_load) begin
            burst_cnt <= sel_burst_len;
        end else if (burst_dec && burst_cnt != '0) begin
            burst_cnt <= burst_cnt - 1'b1;
        end
    end

    assign burst_zero = burst_cnt == '0;

    // address runs on across fills; fill number moves when the checksum is taken
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            word_addr <= '0;
            fill_num  <= '0;
        end else if (word_accepted) begin
            word_addr <= word_addr + 1'b1;
            if (fill_advance) begin
                fill_num <= fill_num + 1'b1;
            end
        end
    end

endmodule

// File: rtl/adc_dummy_source.sv
`timescale 1ns/10ps

module adc_dummy_source (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   dummy_reset,
    input  logic                   sample_advance,
    output adc_acq_pkg::acq_word_t burst_data
);
    import adc_acq_pkg::*;

    // next sample value, wraps at 4096
    sample_t   ramp;
    acq_word_t next_burst;

    // lane k is ramp + k, zero-extended to 16 bits, lane 0 lowest
    always_comb begin
        for (int k = 0; k < SAMPLES_PER_BURST; k++) begin
            next_burst[16*k +: 16] = {4'd0, sample_t'(ramp + k)};
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            ramp <= '0;
        end else if (dummy_reset) begin
            ramp <= '0;
        end else if (sample_advance) begin
            ramp <= ramp + sample_t'(SAMPLES_PER_BURST);
        end
    end

    // burst word held until the next advance
    always_ff @(posedge clk) begin
        if (sample_advance) begin
            burst_data <= next_burst;
        end
    end

endmodule

// File: rtl/adc_word_builder.sv
`timescale 1ns/10ps

module adc_word_builder (
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  logic                    sel_fill_hdr,
    input  logic                    sel_wfm_hdr,
    input  logic                    sel_data,
    input  logic                    sel_csum,
    input  logic                    word_push,
    input  logic                    csum_update,
    input  logic                    out_ready,
    input  adc_acq_pkg::acq_word_t  burst_data,
    input  adc_acq_pkg::fill_type_t fill_type,
    input  adc_acq_pkg::burst_len_t sel_burst_len,
    input  adc_acq_pkg::word_addr_t word_addr,
    input  adc_acq_pkg::fill_num_t  fill_num,
    output logic                    out_valid,
    output adc_acq_pkg::acq_word_t  out_data,
    output adc_acq_pkg::word_addr_t out_addr,
    output logic                    word_accepted
);
    import adc_acq_pkg::*;

    acq_word_t next_word;
    checksum_t checksum;
    checksum_t burst_sum;

    // four 32-bit slices of the current burst
    assign burst_sum = burst_data[31:0] + burst_data[63:32]
                     + burst_data[95:64] + burst_data[127:96];

    // selects are one-hot from the sequencer
    always_comb begin
        next_word = '0;
        if (sel_fill_hdr) begin
            next_word = {FILL_HDR_TAG, fill_num, fill_type, sel_burst_len, 68'd0};
        end else if (sel_wfm_hdr) begin
            // word_addr is the address this header will go out at
            next_word = {WFM_HDR_TAG, fill_num, word_addr, 56'd0};
        end else if (sel_data) begin
            next_word = burst_data;
        end else if (sel_csum) begin
            next_word = {CSUM_TAG, 80'd0, checksum};
        end
    end

    // restarts with each fill header
    always_ff @(posedge clk) begin
        if (sel_fill_hdr) begin
            checksum <= '0;
        end else if (csum_update) begin
            checksum <= checksum + burst_sum;
        end
    end

    assign word_accepted = out_valid & out_ready;

    // one word in flight; the sequencer only pushes after the last one was taken
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            out_valid <= 1'b0;
        end else if (word_push) begin
            out_valid <= 1'b1;
        end else if (word_accepted) begin
            out_valid <= 1'b0;
        end
    end

    // data and address stay put until the next push
    always_ff @(posedge clk) begin
        if (word_push) begin
            out_data <= next_word;
            out_addr <= word_addr;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the adc acquisition testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module adc_acq_tb \
    -f all.f -o sim_adc_acq > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_adc_acq > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
